/* rtl/axi_bridge_config.svh */
`ifndef AXI_BRIDGE_CONFIG_SVH
`define AXI_BRIDGE_CONFIG_SVH

// AXI bus widths
`define AXI_ADDR_W 32
`define AXI_DATA_W 32
`define AXI_ID_W   4

// beats per icache line, arlen carries this minus one
`define ICACHE_BURST_LEN 4

// transaction ids, data reads and writes share one
`define ID_INST 0
`define ID_DATA 1

`endif

/* rtl/axi_bridge_pkg.sv */
`include "axi_bridge_config.svh"

package axi_bridge_pkg;

    // read address channel payload
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [7:0]             len;
        logic [2:0]             size;
        logic [1:0]             burst;
    } axi_ar_t;

    // read data beat
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_DATA_W-1:0] data;
        logic                   last;
    } axi_r_t;

    // write address, single beat so no len or burst
    typedef struct packed {
        logic [`AXI_ID_W-1:0]   id;
        logic [`AXI_ADDR_W-1:0] addr;
        logic [2:0]             size;
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_W-1:0]   data;
        logic [`AXI_DATA_W/8-1:0] strb;
        logic                     last;
    } axi_w_t;

    // data client request, held with data_sram_en until addr_ok
    typedef struct packed {
        logic                     wr;
        logic [1:0]               size;
        logic [`AXI_DATA_W/8-1:0] wstrb;
        logic [`AXI_ADDR_W-1:0]   addr;
        logic [`AXI_DATA_W-1:0]   wdata;
    } data_req_t;

    typedef enum logic [2:0] {
        rd_idle,
        rd_data_check,  // data read waits out a pending write hazard
        rd_data_addr,
        rd_inst_addr,
        rd_wait_resp
    } rreq_state_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_send,        // aw and w in flight
        wr_wait_resp,
        wr_done
    } wr_state_t;

endpackage

/* rtl/read_request_arbiter.sv */
`include "axi_bridge_config.svh"

module read_request_arbiter (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      icache_rd_req,
    input  logic [`AXI_ADDR_W-1:0]    icache_rd_addr,
    input  axi_bridge_pkg::data_req_t data_req,
    input  logic                      data_en,
    input  logic                      write_pending,
    input  logic [`AXI_ADDR_W-1:0]    pending_addr,
    input  logic                      read_done,
    input  logic                      arready,
    output axi_bridge_pkg::axi_ar_t   ar,
    output logic                      arvalid,
    output logic                      icache_rd_rdy,
    output logic                      data_addr_ok,
    output logic                      read_busy,
    output logic                      read_is_data
);

    axi_bridge_pkg::rreq_state_t state;
    axi_bridge_pkg::rreq_state_t state_next;
    logic                        data_rd_req;
    logic                        addr_hazard;
    logic                        load_inst;
    logic                        load_data;

    assign data_rd_req = data_en && !data_req.wr;
    // same address as a write still waiting for bresp
    assign addr_hazard = write_pending && (pending_addr == data_req.addr);

    assign load_inst = (state == axi_bridge_pkg::rd_idle) && !data_rd_req && icache_rd_req;
    assign load_data = (state == axi_bridge_pkg::rd_data_check) && !addr_hazard;

    always_comb begin
        state_next = state;
        case (state)
            axi_bridge_pkg::rd_idle: begin
                if (data_rd_req) begin
                    state_next = axi_bridge_pkg::rd_data_check; // data reads win
                end else if (icache_rd_req) begin
                    state_next = axi_bridge_pkg::rd_inst_addr;
                end
            end
            axi_bridge_pkg::rd_data_check: begin
                if (!addr_hazard) begin
                    state_next = axi_bridge_pkg::rd_data_addr;
                end
            end
            axi_bridge_pkg::rd_data_addr,
            axi_bridge_pkg::rd_inst_addr: begin
                if (arready) begin
                    state_next = axi_bridge_pkg::rd_wait_resp; // arvalid is high here
                end
            end
            axi_bridge_pkg::rd_wait_resp: begin
                if (read_done) begin
                    state_next = axi_bridge_pkg::rd_idle;
                end
            end
            default: state_next = axi_bridge_pkg::rd_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= axi_bridge_pkg::rd_idle;
            read_is_data <= 1'b0;
        end else begin
            state <= state_next;
            if (state == axi_bridge_pkg::rd_idle && (data_rd_req || icache_rd_req)) begin
                read_is_data <= data_rd_req;
            end
        end
    end

    // ar payload loaded once on the way into an address state
    always_ff @(posedge clk) begin
        if (load_inst) begin
            ar.id    <= `AXI_ID_W'(`ID_INST);
            ar.addr  <= icache_rd_addr;
            ar.len   <= 8'(`ICACHE_BURST_LEN - 1);
            ar.size  <= 3'b010;  // full word
            ar.burst <= 2'b01;   // incr
        end else if (load_data) begin
            ar.id    <= `AXI_ID_W'(`ID_DATA);
            ar.addr  <= data_req.addr;
            ar.len   <= 8'd0;
            ar.size  <= {1'b0, data_req.size};
            ar.burst <= 2'b00;   // fixed burst for a single beat
        end
    end

    assign arvalid = (state == axi_bridge_pkg::rd_data_addr) ||
                     (state == axi_bridge_pkg::rd_inst_addr);

    assign icache_rd_rdy = (state == axi_bridge_pkg::rd_inst_addr) && arready;
    assign data_addr_ok  = (state == axi_bridge_pkg::rd_data_addr) && arready;
    assign read_busy     = (state == axi_bridge_pkg::rd_wait_resp);

endmodule

/* rtl/read_response_router.sv */
`include "axi_bridge_config.svh"

module read_response_router (
    input  logic                    clk,
    input  logic                    reset,
    input  axi_bridge_pkg::axi_r_t  r,
    input  logic                    rvalid,
    input  logic                    read_busy,
    input  logic                    read_is_data,
    output logic                    rready,
    output logic                    icache_ret_valid,
    output logic                    icache_ret_last,
    output logic [`AXI_DATA_W-1:0]  icache_ret_data,
    output logic [`AXI_DATA_W-1:0]  data_rdata,
    output logic                    rd_data_ok,
    output logic                    read_done
);

    logic                   beat;
    logic                   inst_beat;
    logic                   data_beat;
    logic [`AXI_DATA_W-1:0] inst_buf;
    logic [`AXI_DATA_W-1:0] data_buf;

    // only accept beats while a read is in flight
    assign rready = read_busy;

    assign beat      = rvalid && rready;
    assign inst_beat = beat && (r.id == `AXI_ID_W'(`ID_INST));
    assign data_beat = beat && (r.id == `AXI_ID_W'(`ID_DATA));

    // data reads are single beat, so rlast is not needed there
    assign read_done = beat && (r.last || read_is_data);

    always_ff @(posedge clk) begin
        if (reset) begin
            icache_ret_valid <= 1'b0;
            icache_ret_last  <= 1'b0;
            rd_data_ok       <= 1'b0;
        end else begin
            icache_ret_valid <= inst_beat;
            icache_ret_last  <= inst_beat && r.last;  // fourth beat of the line
            rd_data_ok       <= data_beat;
        end
    end

    // return buffers, valid only alongside the pulses above
    always_ff @(posedge clk) begin
        if (inst_beat) begin
            inst_buf <= r.data;
        end
        if (data_beat) begin
            data_buf <= r.data;
        end
    end

    assign icache_ret_data = inst_buf;
    assign data_rdata      = data_buf;

endmodule

/* rtl/write_channel.sv */
`include "axi_bridge_config.svh"

module write_channel (
    input  logic                      clk,
    input  logic                      reset,
    input  axi_bridge_pkg::data_req_t data_req,
    input  logic                      data_en,
    input  logic                      awready,
    input  logic                      wready,
    input  logic                      bvalid,
    output axi_bridge_pkg::axi_aw_t   aw,
    output logic                      awvalid,
    output axi_bridge_pkg::axi_w_t    w,
    output logic                      wvalid,
    output logic                      bready,
    output logic                      wr_addr_ok,
    output logic                      wr_data_ok,
    output logic                      write_pending,
    output logic [`AXI_ADDR_W-1:0]    pending_addr
);

    axi_bridge_pkg::wr_state_t state;
    axi_bridge_pkg::wr_state_t state_next;
    logic                      capture;
    logic                      aw_hs;
    logic                      w_hs;
    logic                      aw_done;  // aw handshake already seen
    logic                      w_done;

    assign capture = (state == axi_bridge_pkg::wr_idle) && data_en && data_req.wr;
    assign aw_hs   = awvalid && awready;
    assign w_hs    = wvalid && wready;

    always_comb begin
        state_next = state;
        case (state)
            axi_bridge_pkg::wr_idle: begin
                if (capture) begin
                    state_next = axi_bridge_pkg::wr_send;
                end
            end
            axi_bridge_pkg::wr_send: begin
                // aw and w may finish in either order
                if ((aw_done || aw_hs) && (w_done || w_hs)) begin
                    state_next = axi_bridge_pkg::wr_wait_resp;
                end
            end
            axi_bridge_pkg::wr_wait_resp: begin
                if (bvalid) begin
                    state_next = axi_bridge_pkg::wr_done; // bready is high here
                end
            end
            axi_bridge_pkg::wr_done: state_next = axi_bridge_pkg::wr_idle;
            default: state_next = axi_bridge_pkg::wr_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= axi_bridge_pkg::wr_idle;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_next;
            if (state == axi_bridge_pkg::wr_idle) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_hs) begin
                    aw_done <= 1'b1;
                end
                if (w_hs) begin
                    w_done <= 1'b1;
                end
            end
        end
    end

    // aw and w payload, stable from capture to the b handshake
    always_ff @(posedge clk) begin
        if (capture) begin
            aw.id   <= `AXI_ID_W'(`ID_DATA);
            aw.addr <= data_req.addr;
            aw.size <= {1'b0, data_req.size};
            w.data  <= data_req.wdata;
            w.strb  <= data_req.wstrb;
            w.last  <= 1'b1;  // single beat
        end
    end

    assign awvalid = (state == axi_bridge_pkg::wr_send) && !aw_done;
    assign wvalid  = (state == axi_bridge_pkg::wr_send) && !w_done;
    assign bready  = (state == axi_bridge_pkg::wr_wait_resp);

    assign wr_addr_ok = aw_hs;
    assign wr_data_ok = (state == axi_bridge_pkg::wr_done);

    // hazard window for the read side
    assign write_pending = (state == axi_bridge_pkg::wr_send) ||
                           (state == axi_bridge_pkg::wr_wait_resp);
    assign pending_addr  = aw.addr;

endmodule

/* rtl/axi_bridge_top.sv */
`include "axi_bridge_config.svh"

module axi_bridge_top (
    input  logic                      clk,
    input  logic                      reset,

    // axi master side
    output axi_bridge_pkg::axi_ar_t   ar,
    output logic                      arvalid,
    input  logic                      arready,
    input  axi_bridge_pkg::axi_r_t    r,
    input  logic                      rvalid,
    output logic                      rready,
    output axi_bridge_pkg::axi_aw_t   aw,
    output logic                      awvalid,
    input  logic                      awready,
    output axi_bridge_pkg::axi_w_t    w,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready,

    // icache client
    input  logic                      icache_rd_req,
    input  logic [`AXI_ADDR_W-1:0]    icache_rd_addr,
    output logic                      icache_rd_rdy,
    output logic                      icache_ret_valid,
    output logic                      icache_ret_last,
    output logic [`AXI_DATA_W-1:0]    icache_ret_data,

    // data client
    input  logic                      data_sram_en,
    input  axi_bridge_pkg::data_req_t data_sram_req,
    output logic [`AXI_DATA_W-1:0]    data_sram_rdata,
    output logic                      data_sram_addr_ok,
    output logic                      data_sram_data_ok
);

    logic                   read_done;
    logic                   read_busy;
    logic                   read_is_data;
    logic                   write_pending;
    logic [`AXI_ADDR_W-1:0] pending_addr;
    logic                   data_addr_ok;
    logic                   rd_data_ok;
    logic                   wr_addr_ok;
    logic                   wr_data_ok;

    read_request_arbiter u_rd_arb (
        .clk            (clk),
        .reset          (reset),
        .icache_rd_req  (icache_rd_req),
        .icache_rd_addr (icache_rd_addr),
        .data_req       (data_sram_req),
        .data_en        (data_sram_en),
        .write_pending  (write_pending),
        .pending_addr   (pending_addr),
        .read_done      (read_done),
        .arready        (arready),
        .ar             (ar),
        .arvalid        (arvalid),
        .icache_rd_rdy  (icache_rd_rdy),
        .data_addr_ok   (data_addr_ok),
        .read_busy      (read_busy),
        .read_is_data   (read_is_data)
    );

    read_response_router u_rd_route (
        .clk              (clk),
        .reset            (reset),
        .r                (r),
        .rvalid           (rvalid),
        .read_busy        (read_busy),
        .read_is_data     (read_is_data),
        .rready           (rready),
        .icache_ret_valid (icache_ret_valid),
        .icache_ret_last  (icache_ret_last),
        .icache_ret_data  (icache_ret_data),
        .data_rdata       (data_sram_rdata),
        .rd_data_ok       (rd_data_ok),
        .read_done        (read_done)
    );

    write_channel u_wr (
        .clk           (clk),
        .reset         (reset),
        .data_req      (data_sram_req),
        .data_en       (data_sram_en),
        .awready       (awready),
        .wready        (wready),
        .bvalid        (bvalid),
        .aw            (aw),
        .awvalid       (awvalid),
        .w             (w),
        .wvalid        (wvalid),
        .bready        (bready),
        .wr_addr_ok    (wr_addr_ok),
        .wr_data_ok    (wr_data_ok),
        .write_pending (write_pending),
        .pending_addr  (pending_addr)
    );

    // the data client sees one port for both directions
    assign data_sram_addr_ok = data_addr_ok || wr_addr_ok;
    assign data_sram_data_ok = rd_data_ok || wr_data_ok;

endmodule

/* test/bridge_checker.sv */
`include "axi_bridge_config.svh"

module bridge_checker (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [9:0]                ctrl,  // control outputs that idle low after reset
    input  axi_bridge_pkg::axi_ar_t   ar,
    input  logic                      arvalid,
    input  axi_bridge_pkg::axi_aw_t   aw,
    input  logic                      awvalid,
    input  axi_bridge_pkg::axi_w_t    w,
    input  logic                      wvalid,
    input  logic                      icache_rd_req,
    input  logic [`AXI_ADDR_W-1:0]    icache_rd_addr,
    input  logic                      icache_rd_rdy,
    input  logic                      icache_ret_valid,
    input  logic                      icache_ret_last,
    input  logic [`AXI_DATA_W-1:0]    icache_ret_data,
    input  logic                      data_sram_en,
    input  axi_bridge_pkg::data_req_t data_sram_req,
    input  logic                      data_sram_addr_ok,
    input  logic                      data_sram_data_ok,
    input  logic [`AXI_DATA_W-1:0]    data_sram_rdata,
    input  logic                      exp_use,
    input  logic [`AXI_DATA_W-1:0]    exp_data,
    output int                        errors,
    output int                        pending
);

    logic [31:0] shadow [logic [31:0]];
    logic        data_is_read [$];
    logic [31:0] data_word [$];
    logic [32:0] data_table [$];  // {use, expected word} from the stimulus table
    logic [32:0] inst_word [$];   // {last, word}
    logic        seen_req = 1'b0;
    int          err_count = 0;
    int          pending_cnt = 0;

    assign errors  = err_count;
    assign pending = pending_cnt;

    // memory contents before any write
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        fill_word = {a[31:16] ^ a[15:0] ^ 16'h5a5a, ~a[15:0]};
    endfunction

    function logic [31:0] shadow_read(input logic [31:0] a);
        if (shadow.exists({a[31:2], 2'b00})) begin
            shadow_read = shadow[{a[31:2], 2'b00}];
        end else begin
            shadow_read = fill_word({a[31:2], 2'b00});
        end
    endfunction

    function automatic logic [31:0] strobe_merge(input logic [31:0] old_w,
                                                 input logic [31:0] new_w,
                                                 input logic [3:0]  strb);
        int i;
        for (i = 0; i < 4; i++) begin
            strobe_merge[8*i +: 8] = strb[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
        end
    endfunction

    // sampled at the falling edge where all DUT outputs are settled
    always @(negedge clk) begin : sample
        logic        is_rd;
        logic [31:0] word;
        logic [32:0] tab;
        logic [32:0] head;
        int          i;
        if (reset) begin
            seen_req = 1'b0;
        end else begin
            if (!seen_req && ctrl != 10'd0) begin
                err_count++;
                $display("control output high after reset before any request: %h", ctrl);
            end
            if (icache_rd_req || data_sram_en) seen_req = 1'b1;

            // icache line fetch is a four beat incrementing word burst
            if (arvalid && ar.id == `AXI_ID_W'(`ID_INST)) begin
                if (ar.len !== 8'd3) begin
                    err_count++;
                    $display("error ar.len got %h expected 03", ar.len);
                end
                if (ar.size !== 3'd2 || ar.burst !== 2'b01) begin
                    err_count++;
                    $display("error ar.size ar.burst got %h %h expected 2 1", ar.size,
                             ar.burst);
                end
            end
            if (arvalid && ar.id == `AXI_ID_W'(`ID_DATA) &&
                {ar.len, ar.size} !== {8'd0, 1'b0, data_sram_req.size}) begin
                err_count++;
                $display("error ar.len ar.size got %h %h expected 00 %h", ar.len, ar.size,
                         data_sram_req.size);
            end
            if (awvalid && {aw.id, aw.size, aw.addr} !==
                {4'd1, 1'b0, data_sram_req.size, data_sram_req.addr}) begin
                err_count++;
                $display("error aw got %h expected %h", {aw.id, aw.size, aw.addr},
                         {4'd1, 1'b0, data_sram_req.size, data_sram_req.addr});
            end
            if (wvalid && w.last !== 1'b1) begin
                err_count++;
                $display("error w.last got %h expected 1", w.last);
            end

            if (data_sram_data_ok) begin
                if (data_is_read.size() == 0) begin
                    err_count++;
                    $display("data_sram_data_ok with no data request outstanding");
                end else begin
                    is_rd = data_is_read.pop_front();
                    word  = data_word.pop_front();
                    tab   = data_table.pop_front();
                    if (is_rd && data_sram_rdata !== word) begin
                        err_count++;
                        $display("error data_sram_rdata got %h expected %h", data_sram_rdata,
                                 word);
                    end
                    if (is_rd && tab[32] && data_sram_rdata !== tab[31:0]) begin
                        err_count++;
                        $display("error data_sram_rdata got %h table %h", data_sram_rdata,
                                 tab[31:0]);
                    end
                end
            end

            if (data_sram_addr_ok) begin
                if (!data_sram_en) begin
                    err_count++;
                    $display("data_sram_addr_ok without a data request");
                end else if (data_sram_req.wr) begin
                    shadow[{data_sram_req.addr[31:2], 2'b00}] = strobe_merge(
                        shadow_read(data_sram_req.addr), data_sram_req.wdata,
                        data_sram_req.wstrb);
                    data_is_read.push_back(1'b0);
                    data_word.push_back(32'd0);
                    data_table.push_back(33'd0);
                end else begin
                    data_is_read.push_back(1'b1);
                    data_word.push_back(shadow_read(data_sram_req.addr));
                    data_table.push_back({exp_use, exp_data});
                end
            end

            if (icache_ret_last && !icache_ret_valid) begin
                err_count++;
                $display("icache_ret_last high without icache_ret_valid");
            end
            if (icache_ret_valid) begin
                if (inst_word.size() == 0) begin
                    err_count++;
                    $display("icache_ret_valid with no icache line outstanding");
                end else begin
                    head = inst_word.pop_front();
                    if (icache_ret_data !== head[31:0]) begin
                        err_count++;
                        $display("error icache_ret_data got %h expected %h", icache_ret_data,
                                 head[31:0]);
                    end
                    if (icache_ret_last !== head[32]) begin
                        err_count++;
                        $display("error icache_ret_last got %h expected %h", icache_ret_last,
                                 head[32]);
                    end
                end
            end

            if (icache_rd_rdy) begin
                if (data_sram_en && !data_sram_req.wr) begin
                    err_count++;
                    $display("icache read accepted while a data read was waiting");
                end
                for (i = 0; i < `ICACHE_BURST_LEN; i++) begin
                    inst_word.push_back({i == `ICACHE_BURST_LEN - 1,
                                         shadow_read(icache_rd_addr + 32'(4 * i))});
                end
            end
        end
        pending_cnt = data_is_read.size() + inst_word.size();
    end

endmodule

/* test/tb_axi_bridge.sv */
`include "axi_bridge_config.svh"

module tb_axi_bridge;

    localparam logic [2:0] K_WR    = 3'd0;
    localparam logic [2:0] K_RD    = 3'd1;
    localparam logic [2:0] K_IC    = 3'd2;
    localparam logic [2:0] K_WR_RD = 3'd3;  // read issued while the write is pending
    localparam logic [2:0] K_IC_RD = 3'd4;  // icache at addr + 0x80 with a data read at addr
    localparam int         N_TESTS = 12;

    typedef struct packed {
        logic [2:0]  kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] expect_word;
        logic        check;
    } test_entry_t;

    // kind, address, data, strobe, expected read word, expected word valid
    test_entry_t tests [N_TESTS] = '{
        '{K_WR,    32'h100, 32'h11223344, 4'hf, 32'h0,        1'b0},
        '{K_WR,    32'h100, 32'haabbccdd, 4'h5, 32'h0,        1'b0},
        '{K_RD,    32'h100, 32'h0,        4'h0, 32'h11bb33dd, 1'b1},
        '{K_IC,    32'h100, 32'h0,        4'h0, 32'h0,        1'b0},
        '{K_WR_RD, 32'h200, 32'hcafef00d, 4'hf, 32'hcafef00d, 1'b1},
        '{K_WR_RD, 32'h300, 32'h12345678, 4'h3, 32'h595a5678, 1'b1},
        '{K_IC_RD, 32'h200, 32'h0,        4'h0, 32'hcafef00d, 1'b1},
        '{K_IC_RD, 32'h300, 32'h0,        4'h0, 32'h595a5678, 1'b1},
        '{K_WR,    32'h404, 32'h0badcafe, 4'h8, 32'h0,        1'b0},
        '{K_RD,    32'h404, 32'h0,        4'h0, 32'h0b5efbfb, 1'b1},
        '{K_IC,    32'h400, 32'h0,        4'h0, 32'h0,        1'b0},
        '{K_RD,    32'h500, 32'h0,        4'h0, 32'h0,        1'b0}
    };

    logic clk = 1'b0;
    logic reset;
    axi_bridge_pkg::axi_ar_t   ar;
    axi_bridge_pkg::axi_r_t    r;
    axi_bridge_pkg::axi_aw_t   aw;
    axi_bridge_pkg::axi_w_t    w;
    axi_bridge_pkg::data_req_t data_sram_req;
    logic arvalid, arready, rvalid, rready, awvalid, awready, wvalid, wready, bvalid, bready;
    logic icache_rd_req, icache_rd_rdy, icache_ret_valid, icache_ret_last;
    logic [31:0] icache_rd_addr, icache_ret_data, data_sram_rdata, exp_data;
    logic data_sram_en, data_sram_addr_ok, data_sram_data_ok, exp_use;
    int errors, pending;
    integer seed = 32'hf90a;
    logic [31:0] mem [logic [31:0]];  // slave memory by word address

    always #4 clk = ~clk;

    axi_bridge_top u_dut (.*);

    bridge_checker u_chk (
        .ctrl ({arvalid, awvalid, wvalid, bready, rready, icache_rd_rdy, icache_ret_valid,
                icache_ret_last, data_sram_addr_ok, data_sram_data_ok}),
        .*
    );

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        fill_word = {a[31:16] ^ a[15:0] ^ 16'h5a5a, ~a[15:0]};
    endfunction

    function logic [31:0] mem_read(input logic [31:0] a);
        if (mem.exists(a)) begin
            mem_read = mem[a];
        end else begin
            mem_read = fill_word(a);
        end
    endfunction

    function automatic logic [31:0] lane_merge(input logic [31:0] old_w, input logic [31:0] new_w,
                                               input logic [3:0] strb);
        int i;
        for (i = 0; i < 4; i++) begin
            lane_merge[8*i +: 8] = strb[i] ? new_w[8*i +: 8] : old_w[8*i +: 8];
        end
    endfunction

    function int rand_delay();
        rand_delay = {$random(seed)} % 4;
    endfunction

    task step();
        @(posedge clk);
        #1;
    endtask

    task automatic data_request(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        logic ok;
        data_sram_en        = 1'b1;
        data_sram_req.wr    = wr;
        data_sram_req.size  = 2'd2;
        data_sram_req.wstrb = strb;
        data_sram_req.addr  = addr;
        data_sram_req.wdata = data;
        do begin
            @(negedge clk);
            ok = data_sram_addr_ok;
            step();
        end while (!ok);
        data_sram_en = 1'b0;
    endtask

    task automatic icache_request(input logic [31:0] addr);
        logic ok;
        icache_rd_req  = 1'b1;
        icache_rd_addr = addr;
        do begin
            @(negedge clk);
            ok = icache_rd_rdy;
            step();
        end while (!ok);
        icache_rd_req = 1'b0;
    endtask

    // read side of the slave handles one burst at a time
    initial begin : read_slave
        axi_bridge_pkg::axi_ar_t req;
        int   beat;
        logic hs;
        arready = 1'b0;
        rvalid  = 1'b0;
        r       = '0;
        forever begin
            step();
            if (!reset && arvalid) begin
                repeat (rand_delay()) step();
                req     = ar;
                arready = 1'b1;
                step();
                arready = 1'b0;
                for (beat = 0; beat <= 32'(req.len); beat++) begin
                    repeat (rand_delay()) step();
                    r.id   = req.id;
                    r.data = mem_read({req.addr[31:2], 2'b00} + 32'(4 * beat));
                    r.last = (beat == 32'(req.len));
                    rvalid = 1'b1;
                    do begin
                        @(negedge clk);
                        hs = rready;
                        step();
                    end while (!hs);
                    rvalid = 1'b0;
                end
            end
        end
    end

    // write side updates memory only when the response goes out
    initial begin : write_slave
        logic [31:0] wa;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        hs;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        forever begin
            step();
            if (!reset && awvalid) begin
                repeat (rand_delay()) step();
                wa      = {aw.addr[31:2], 2'b00};
                awready = 1'b1;
                step();
                awready = 1'b0;
                repeat (rand_delay()) step();
                wdata  = w.data;
                wstrb  = w.strb;
                wready = 1'b1;
                step();
                wready = 1'b0;
                repeat (rand_delay()) step();
                mem[wa] = lane_merge(mem_read(wa), wdata, wstrb);
                bvalid  = 1'b1;
                do begin
                    @(negedge clk);
                    hs = bready;
                    step();
                end while (!hs);
                bvalid = 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (10 + N_TESTS * 64) @(posedge clk);
        $display("timeout: requests still outstanding after %0d cycles", 10 + N_TESTS * 64);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : main
        int n;
        reset          = 1'b1;
        icache_rd_req  = 1'b0;
        icache_rd_addr = '0;
        data_sram_en   = 1'b0;
        data_sram_req  = '0;
        exp_use        = 1'b0;
        exp_data       = '0;
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        repeat (3) step();  // quiet window for the reset check
        for (n = 0; n < N_TESTS; n++) begin
            exp_use  = tests[n].check;
            exp_data = tests[n].expect_word;
            case (tests[n].kind)
                K_WR: data_request(1'b1, tests[n].addr, tests[n].data, tests[n].strb);
                K_RD: data_request(1'b0, tests[n].addr, 32'h0, 4'h0);
                K_IC: icache_request(tests[n].addr);
                K_WR_RD: begin
                    data_request(1'b1, tests[n].addr, tests[n].data, tests[n].strb);
                    data_request(1'b0, tests[n].addr, 32'h0, 4'h0);
                end
                default: begin
                    fork
                        icache_request(tests[n].addr + 32'h80);
                        data_request(1'b0, tests[n].addr, 32'h0, 4'h0);
                    join
                end
            endcase
            do step(); while (pending != 0);
        end
        repeat (4) step();
        $display("checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+rtl
rtl/axi_bridge_pkg.sv
rtl/read_request_arbiter.sv
rtl/read_response_router.sv
rtl/write_channel.sv
rtl/axi_bridge_top.sv
test/bridge_checker.sv
test/tb_axi_bridge.sv

/* Makefile */
SIM := obj_dir/Vtb_axi_bridge
SRCS := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): all.f $(SRCS)
	verilator --binary --timing --top-module tb_axi_bridge -f all.f -o Vtb_axi_bridge

run: $(SIM)
	./$(SIM) | tee sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
